//--- Makefile
# Verilator build and run for the pipeline control core testbench

SIM = obj_dir/pipe_ctrl_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if sim.log holds the pass line"
	@echo "  clean  remove build output and sim.log"

test:
	verilator --binary --timing -f tb.f --top-module pipe_ctrl_tb -Mdir obj_dir -o pipe_ctrl_sim
	./$(SIM) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- include/pipe_settings.svh
//------------------------------
// widths, reset PC and PC step for the pipeline control core
// included by the package and by RTL that sizes ports or PCs
//------------------------------
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

`define PIPE_XLEN 32
`define PIPE_REG_AW 5
`define PIPE_RESET_PC 32'h0000_0000
// sequential fetch increment, one 32-bit instruction
`define PIPE_PC_STEP 32'd4

`endif

//--- tb.f
+incdir+include
verilog/riscv_pkg.sv
verilog/controller.sv
verilog/pipe_reg.sv
verilog/fetch_pc.sv
verilog/trap_csr.sv
verilog/pipe_ctrl_top.sv
verif/tb_clk_gen.sv
verif/pipe_ctrl_tb.sv

//--- verif/pipe_ctrl_tb.sv
//------------------------------
// testbench for the pipeline control core, replays the testdata vectors
// drives on the falling edge, checks just before the next one
//------------------------------
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_ctrl_tb;

    localparam int VEC_WORDS   = 14;
    localparam int MAX_WORDS   = 4096;
    localparam int VEC_TIMEOUT = 200;

    logic                 clk;
    logic                 rst_n;
    riscv_pkg::id_pkt_t   id_pkt;
    logic [31:0]          alu_result;
    logic [31:0]          dmem_rdata;
    logic                 ex_new_pc_en;
    logic [31:0]          jump_target;
    logic                 csr_we;
    logic [31:0]          csr_wdata;
    riscv_pkg::fwd_t      fwd;
    riscv_pkg::pipe_ctl_t ctl;
    logic [31:0]          pc;
    logic [31:0]          mepc;
    logic [7:0]           mret_count;

    logic [31:0] vec_mem [0:MAX_WORDS-1];
    // mepc expected from the CSR writes driven so far
    logic [31:0] exp_mepc;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          total_errs;

    tb_clk_gen i_tb_clk_gen (
        .clk_o (clk)
    );

    pipe_ctrl_top i_pipe_ctrl_top (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .id_pkt_i       (id_pkt),
        .alu_result_i   (alu_result),
        .dmem_rdata_i   (dmem_rdata),
        .ex_new_pc_en_i (ex_new_pc_en),
        .jump_target_i  (jump_target),
        .csr_we_i       (csr_we),
        .csr_wdata_i    (csr_wdata),
        .fwd_o          (fwd),
        .ctl_o          (ctl),
        .pc_o           (pc),
        .mepc_o         (mepc),
        .mret_count_o   (mret_count)
    );

    function automatic string test_name(input int num);
        case (num)
            1:       return "reset";
            2:       return "forwarding";
            3:       return "load_use";
            4:       return "branch_redirect";
            5:       return "csr_serialize";
            6:       return "mret_return";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input string name, input int vec_no, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[FAIL] %s vector %0d %s expected %h actual %h",
                 name, vec_no, what, expected, actual);
        test_errs++;
    endtask

    task automatic finish_test(input int num);
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0)
            tests_failed++;
        $display("test %0d %s: %0d mismatches, %s", num, test_name(num), test_errs,
                 (test_errs == 0) ? "ok" : "failed");
        test_errs = 0;
    endtask

    // word 1 packs rs1, rs2, rd bytes and the flag bits of the packet
    task automatic drive_vector(input int base);
        id_pkt            = '0;
        id_pkt.valid      = vec_mem[base+1][0];
        id_pkt.write_rd   = vec_mem[base+1][1];
        id_pkt.wb_use_mem = vec_mem[base+1][2];
        id_pkt.is_csr     = vec_mem[base+1][3];
        id_pkt.is_mret    = riscv_pkg::exc_t'(vec_mem[base+1][5:4]);
        id_pkt.rs1_addr   = vec_mem[base+1][28:24];
        id_pkt.rs2_addr   = vec_mem[base+1][20:16];
        id_pkt.rd_addr    = vec_mem[base+1][12:8];
        id_pkt.pc         = vec_mem[base+2];
        alu_result        = vec_mem[base+3];
        dmem_rdata        = vec_mem[base+4];
        jump_target       = vec_mem[base+5];
        ex_new_pc_en      = vec_mem[base+6][0];
        csr_we            = vec_mem[base+6][4];
        csr_wdata         = vec_mem[base+7];
    endtask

    task automatic check_vector(input int base, input string name, input int vec_no);
        riscv_pkg::pipe_ctl_t exp_ctl;
        logic [3:0]           exp_flags;
        logic [3:0]           act_flags;
        logic [31:0]          fw;
        logic [31:0]          cw;

        fw = vec_mem[base+8];
        cw = vec_mem[base+11];
        // one hex digit per forward select, data checks enabled by digits 4 and 5
        exp_flags = {fw[12], fw[8], fw[4], fw[0]};
        act_flags = {fwd.forward_mem_wb_rs2, fwd.forward_mem_wb_rs1,
                     fwd.forward_ex_mem_rs2, fwd.forward_ex_mem_rs1};
        if (act_flags !== exp_flags)
            report_mismatch(name, vec_no, "fwd selects", {28'd0, exp_flags}, {28'd0, act_flags});
        if (fw[16] && (fwd.forward_ex_mem_data !== vec_mem[base+9]))
            report_mismatch(name, vec_no, "ex_mem data", vec_mem[base+9],
                            fwd.forward_ex_mem_data);
        if (fw[20] && (fwd.forward_mem_wb_data !== vec_mem[base+10]))
            report_mismatch(name, vec_no, "mem_wb data", vec_mem[base+10],
                            fwd.forward_mem_wb_data);

        // ID/EX and EX/MEM stalls are always low
        exp_ctl              = '0;
        exp_ctl.if_id_flush  = cw[24];
        exp_ctl.if_id_stall  = cw[20];
        exp_ctl.id_ex_flush  = cw[16];
        exp_ctl.ex_mem_flush = cw[12];
        exp_ctl.new_pc_en    = cw[8];
        exp_ctl.pc_sel       = riscv_pkg::pc_sel_t'(cw[4]);
        exp_ctl.csr_mret     = cw[0];
        if (ctl !== exp_ctl)
            report_mismatch(name, vec_no, "ctl", {23'd0, exp_ctl}, {23'd0, ctl});
        if (pc !== vec_mem[base+12])
            report_mismatch(name, vec_no, "pc", vec_mem[base+12], pc);
        if ({24'd0, mret_count} !== vec_mem[base+13])
            report_mismatch(name, vec_no, "mret_count", vec_mem[base+13], {24'd0, mret_count});
        if (mepc !== exp_mepc)
            report_mismatch(name, vec_no, "mepc", exp_mepc, mepc);
    endtask

    task automatic check_reset();
        logic [3:0] act_flags;

        act_flags = {fwd.forward_mem_wb_rs2, fwd.forward_mem_wb_rs1,
                     fwd.forward_ex_mem_rs2, fwd.forward_ex_mem_rs1};
        if (pc !== `PIPE_RESET_PC)
            report_mismatch("reset", 0, "pc", `PIPE_RESET_PC, pc);
        if (ctl !== '0)
            report_mismatch("reset", 0, "ctl", 32'd0, {23'd0, ctl});
        if (act_flags !== 4'd0)
            report_mismatch("reset", 0, "fwd selects", 32'd0, {28'd0, act_flags});
        if (mepc !== 32'd0)
            report_mismatch("reset", 0, "mepc", 32'd0, mepc);
        if (mret_count !== 8'd0)
            report_mismatch("reset", 0, "mret_count", 32'd0, {24'd0, mret_count});
    endtask

    initial
    begin
        int base;
        int vec_no;
        int cycles;
        int prev_test;
        int cur_test;
        int rst_cycles;
        bit timed_out;
        bit no_vectors;

        rst_n        = 1'b0;
        id_pkt       = '0;
        alu_result   = '0;
        dmem_rdata   = '0;
        ex_new_pc_en = 1'b0;
        jump_target  = '0;
        csr_we       = 1'b0;
        csr_wdata    = '0;
        exp_mepc     = '0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        total_errs   = 0;
        $readmemh("verif/pipe_ctrl_testdata.hex", vec_mem);

        // reset held for 10 rising edges, state checked while still in reset
        rst_cycles = 0;
        while (rst_cycles < 10)
        begin
            @(posedge clk);
            rst_cycles++;
        end
        #3;
        check_reset();
        finish_test(1);

        @(negedge clk);
        rst_n      = 1'b1;
        base       = 0;
        vec_no     = 0;
        cycles     = 0;
        prev_test  = 0;
        timed_out  = 1'b0;
        no_vectors = 1'b0;
        // one vector per cycle until the ffffffff end marker
        while ((vec_mem[base] !== 32'hffff_ffff) && !timed_out)
        begin
            if (cycles >= VEC_TIMEOUT)
            begin
                $display("timeout: end of test vectors not reached in %0d cycles", VEC_TIMEOUT);
                timed_out = 1'b1;
            end
            else
            begin
                cur_test = int'(vec_mem[base]);
                if ((prev_test != 0) && (cur_test != prev_test))
                    finish_test(prev_test);
                prev_test = cur_test;
                drive_vector(base);
                @(posedge clk);
                #3;
                // mepc takes the write data at the edge that samples the strobe
                if (csr_we)
                    exp_mepc = csr_wdata;
                vec_no++;
                check_vector(base, test_name(cur_test), vec_no);
                @(negedge clk);
                base += VEC_WORDS;
                cycles++;
            end
        end
        if (prev_test != 0)
            finish_test(prev_test);
        if (vec_no == 0)
        begin
            $display("no test vectors were found in the testdata file");
            no_vectors = 1'b1;
        end

        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
                 total_errs);
        if ((tests_failed == 0) && !timed_out && !no_vectors)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verif/pipe_ctrl_testdata.hex
// line a: test id_pkt(rs1 rs2 rd flags) pc alu dmem jump_target strobes csr_wdata
// line b: fwd_sel/check data_exm data_mwb ctl_digits pc mret_count
00000002 01020503 00000000 0000a001 0000d001 00000000 00000010 00000080
00000000 00000000 00000000 00000000 00000004 00000000
00000002 03040503 00000004 0000a002 0000d002 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000008 00000000
00000002 05050603 00000008 0000a003 0000d003 00000000 00000000 00000000
00000000 00000000 00000000 00000000 0000000c 00000000
00000002 09090003 0000000c 0000a004 0000d004 00000000 00000000 00000000
00110011 0000a004 0000a003 00000000 00000010 00000000
00000002 06000703 00000010 0000a005 0000d005 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000014 00000000
00000002 00000000 00000000 0000a006 0000d006 00000000 00000000 00000000
00110100 0000a006 0000a005 00000000 00000018 00000000
00000003 01000807 00000018 0000a007 0000d007 00000000 00000000 00000000
00000000 00000000 00000000 00000000 0000001c 00000000
00000003 08020903 0000001c 0000a008 0000d008 00000000 00000000 00000000
00000000 00000000 00000000 00110000 00000020 00000000
00000003 08020903 0000001c 0000a009 0000d009 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000020 00000000
00000003 00000000 00000000 0000a00a 0000d00a 00000000 00000000 00000000
00100100 00000000 0000d00a 00000000 00000024 00000000
00000004 01020001 00000024 0000a00b 0000d00b 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000028 00000000
00000004 03040a03 00000028 0000a00c 0000d00c 00000000 00000000 00000000
00000000 00000000 00000000 00000000 0000002c 00000000
00000004 05060b03 0000002c 0000a00d 0000d00d 00000200 00000001 00000000
00000000 00000000 00000000 00010100 00000200 00000000
00000004 00000000 00000000 0000a00e 0000d00e 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000204 00000000
00000005 01000c0b 00000204 0000a00f 0000d00f 00000000 00000000 00000000
00000000 00000000 00000000 01000000 00000208 00000000
00000005 02030d03 00000208 0000a010 0000d010 00000000 00000000 00000000
00000000 00000000 00000000 01100000 0000020c 00000000
00000005 00000000 00000000 0000a011 0000d011 00000000 00000000 00000000
00000000 00000000 00000000 01100000 0000020c 00000000
00000005 00000000 00000000 0000a012 0000d012 00000000 00000000 00000000
00000000 00000000 00000000 00000000 0000020c 00000000
00000006 00000011 0000020c 0000a013 0000d013 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000210 00000000
00000006 01020e03 00000210 0000a014 0000d014 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000214 00000000
00000006 03040f03 00000214 0000a015 0000d015 00000000 00000000 00000000
00000000 00000000 00000000 00011111 00000218 00000000
00000006 00000000 00000000 0000a016 0000d016 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000080 00000001
ffffffff

//--- verif/tb_clk_gen.sv
//------------------------------
// free running testbench clock, 8 ns period
//------------------------------
`timescale 1ns/100ps

module tb_clk_gen
#(
    parameter int HALF_PERIOD_NS = 4
)
(
    output logic clk_o
);

    // starts low so the first edge is a rising one at half a period
    initial
    begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

//--- verilog/controller.sv
//------------------------------
// hazard detection, operand forwarding and PC steering
// purely combinational, sits beside the stage registers
//------------------------------
`timescale 1ns/100ps

module controller
(
    // clock and reset unused, all decisions are combinational
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // instruction in ID, taken from the IF/ID register
    input  riscv_pkg::id_pkt_t   id_pkt_i,
    // instruction in EX
    input  riscv_pkg::id_pkt_t   id_ex_pkt_i,
    // instruction in MEM
    input  riscv_pkg::ex_pkt_t   ex_mem_pkt_i,
    // instruction in WB
    input  riscv_pkg::mem_pkt_t  mem_wb_pkt_i,

    // branch or jump resolved taken in EX
    input  logic                 ex_new_pc_en_i,

    output riscv_pkg::fwd_t      fwd_o,
    output riscv_pkg::pipe_ctl_t ctl_o
);

    logic instr_valid;
    logic ex_mem_fwd_ok;
    logic mem_wb_fwd_ok;
    logic id_ex_load;
    logic load_use_hzrd;
    logic csr_in_ex_mem;
    logic mret_in_mem;

    assign instr_valid = id_pkt_i.valid;

    // EX/MEM holds an address rather than the result for a load
    assign ex_mem_fwd_ok = (ex_mem_pkt_i.id.rd_addr != '0) && ex_mem_pkt_i.id.write_rd &&
                           !ex_mem_pkt_i.id.wb_use_mem;
    // x0 is never a forwarding source
    assign mem_wb_fwd_ok = (mem_wb_pkt_i.ex.id.rd_addr != '0) && mem_wb_pkt_i.ex.id.write_rd;

    // forwarding into EX, the youngest producer wins
    always_comb
    begin
        fwd_o = '0;

        // rs1
        if (ex_mem_fwd_ok && (ex_mem_pkt_i.id.rd_addr == id_ex_pkt_i.rs1_addr))
            fwd_o.forward_ex_mem_rs1 = 1'b1;
        else if (mem_wb_fwd_ok && (mem_wb_pkt_i.ex.id.rd_addr == id_ex_pkt_i.rs1_addr))
            fwd_o.forward_mem_wb_rs1 = 1'b1;

        // rs2
        if (ex_mem_fwd_ok && (ex_mem_pkt_i.id.rd_addr == id_ex_pkt_i.rs2_addr))
            fwd_o.forward_ex_mem_rs2 = 1'b1;
        else if (mem_wb_fwd_ok && (mem_wb_pkt_i.ex.id.rd_addr == id_ex_pkt_i.rs2_addr))
            fwd_o.forward_mem_wb_rs2 = 1'b1;

        fwd_o.forward_ex_mem_data = ex_mem_pkt_i.alu_result;
        // loads write back memory data, everything else the ALU result
        fwd_o.forward_mem_wb_data = mem_wb_pkt_i.ex.id.wb_use_mem ? mem_wb_pkt_i.dmem_rdata :
                                                                    mem_wb_pkt_i.ex.alu_result;
    end

    // load in EX feeding the instruction in ID, one bubble then MEM/WB forward
    assign id_ex_load    = id_ex_pkt_i.write_rd && id_ex_pkt_i.wb_use_mem;
    assign load_use_hzrd = id_ex_load && instr_valid &&
                           ((id_ex_pkt_i.rd_addr == id_pkt_i.rs1_addr) ||
                            (id_ex_pkt_i.rd_addr == id_pkt_i.rs2_addr));

    // CSR side effects are serialized, fetch waits while one is in flight
    assign csr_in_ex_mem = id_ex_pkt_i.is_csr || ex_mem_pkt_i.id.is_csr;

    // only MRET is acted on, other trap kinds pass through
    assign mret_in_mem = (ex_mem_pkt_i.id.is_mret == riscv_pkg::MRET);

    always_comb
    begin
        ctl_o = '0;

        // fetch side
        ctl_o.if_id_stall = load_use_hzrd || csr_in_ex_mem;
        ctl_o.if_id_flush = id_pkt_i.is_csr || csr_in_ex_mem;

        // not-taken prediction, a redirect squashes the younger instruction in ID
        ctl_o.id_ex_flush = ex_new_pc_en_i || load_use_hzrd || mret_in_mem;
        ctl_o.id_ex_stall = 1'b0;

        // MRET in MEM squashes everything behind it
        ctl_o.ex_mem_flush = mret_in_mem;
        ctl_o.ex_mem_stall = 1'b0;

        // PC steering
        if (mret_in_mem)
        begin
            ctl_o.new_pc_en = 1'b1;
            ctl_o.pc_sel    = riscv_pkg::PC_MEPC;
            ctl_o.csr_mret  = 1'b1;
        end
        else
        begin
            ctl_o.new_pc_en = ex_new_pc_en_i;
            ctl_o.pc_sel    = riscv_pkg::PC_JUMP;
            ctl_o.csr_mret  = 1'b0;
        end
    end

endmodule

//--- verilog/fetch_pc.sv
//------------------------------
// fetch PC register
// steps, holds on IF/ID stall, or takes a redirect target
//------------------------------
`timescale 1ns/100ps
`include "pipe_settings.svh"

module fetch_pc
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  new_pc_en_i,
    input  riscv_pkg::pc_sel_t    pc_sel_i,
    input  logic [`PIPE_XLEN-1:0] jump_target_i,
    input  logic [`PIPE_XLEN-1:0] mepc_i,
    output logic [`PIPE_XLEN-1:0] pc_o
);

    logic [`PIPE_XLEN-1:0] pc_q;
    logic [`PIPE_XLEN-1:0] redirect_pc;

    // branch target from EX or return address from the trap CSR
    assign redirect_pc = (pc_sel_i == riscv_pkg::PC_MEPC) ? mepc_i : jump_target_i;

    // redirect has priority over stall
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            pc_q <= `PIPE_RESET_PC;
        else if (new_pc_en_i)
            pc_q <= redirect_pc;
        else if (!stall_i)
            pc_q <= pc_q + `PIPE_PC_STEP;
    end

    assign pc_o = pc_q;

endmodule

//--- verilog/pipe_ctrl_top.sv
//------------------------------
// pipeline control core top, stage registers around the controller
// datapath values come in from outside each cycle
//------------------------------
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_ctrl_top
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  riscv_pkg::id_pkt_t    id_pkt_i,
    input  logic [`PIPE_XLEN-1:0] alu_result_i,
    input  logic [`PIPE_XLEN-1:0] dmem_rdata_i,
    input  logic                  ex_new_pc_en_i,
    input  logic [`PIPE_XLEN-1:0] jump_target_i,
    input  logic                  csr_we_i,
    input  logic [`PIPE_XLEN-1:0] csr_wdata_i,
    output riscv_pkg::fwd_t       fwd_o,
    output riscv_pkg::pipe_ctl_t  ctl_o,
    output logic [`PIPE_XLEN-1:0] pc_o,
    output logic [`PIPE_XLEN-1:0] mepc_o,
    output logic [7:0]            mret_count_o
);

    riscv_pkg::pipe_ctl_t  ctl;
    riscv_pkg::id_pkt_t    if_id_q;
    riscv_pkg::id_pkt_t    id_ex_q;
    riscv_pkg::ex_pkt_t    ex_mem_d;
    riscv_pkg::ex_pkt_t    ex_mem_q;
    riscv_pkg::mem_pkt_t   mem_wb_d;
    riscv_pkg::mem_pkt_t   mem_wb_q;
    logic [`PIPE_XLEN-1:0] mepc;

    // EX adds the ALU result, MEM adds the load data
    assign ex_mem_d.id         = id_ex_q;
    assign ex_mem_d.alu_result = alu_result_i;
    assign mem_wb_d.ex         = ex_mem_q;
    assign mem_wb_d.dmem_rdata = dmem_rdata_i;

    controller i_controller (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .id_pkt_i       (if_id_q),
        .id_ex_pkt_i    (id_ex_q),
        .ex_mem_pkt_i   (ex_mem_q),
        .mem_wb_pkt_i   (mem_wb_q),
        .ex_new_pc_en_i (ex_new_pc_en_i),
        .fwd_o          (fwd_o),
        .ctl_o          (ctl)
    );

    pipe_reg #(.payload_t(riscv_pkg::id_pkt_t)) i_if_id (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (ctl.if_id_stall),
        .flush_i (ctl.if_id_flush),
        .d_i     (id_pkt_i),
        .q_o     (if_id_q)
    );

    pipe_reg #(.payload_t(riscv_pkg::id_pkt_t)) i_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (ctl.id_ex_stall),
        .flush_i (ctl.id_ex_flush),
        .d_i     (if_id_q),
        .q_o     (id_ex_q)
    );

    pipe_reg #(.payload_t(riscv_pkg::ex_pkt_t)) i_ex_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (ctl.ex_mem_stall),
        .flush_i (ctl.ex_mem_flush),
        .d_i     (ex_mem_d),
        .q_o     (ex_mem_q)
    );

    // writeback stage never stalls or flushes
    pipe_reg #(.payload_t(riscv_pkg::mem_pkt_t)) i_mem_wb (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (mem_wb_d),
        .q_o     (mem_wb_q)
    );

    fetch_pc i_fetch_pc (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (ctl.if_id_stall),
        .new_pc_en_i   (ctl.new_pc_en),
        .pc_sel_i      (ctl.pc_sel),
        .jump_target_i (jump_target_i),
        .mepc_i        (mepc),
        .pc_o          (pc_o)
    );

    trap_csr i_trap_csr (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .csr_we_i     (csr_we_i),
        .csr_wdata_i  (csr_wdata_i),
        .mret_i       (ctl.csr_mret),
        .mepc_o       (mepc),
        .mret_count_o (mret_count_o)
    );

    assign ctl_o  = ctl;
    assign mepc_o = mepc;

endmodule

//--- verilog/pipe_reg.sv
//------------------------------
// generic pipeline stage register
// payload type set per stage, flush loads a bubble
//------------------------------
`timescale 1ns/100ps

module pipe_reg
#(
    parameter type payload_t = logic [31:0]
)
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t stage_q;

    // flush beats stall, a zero payload is a bubble with valid low
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i || flush_i)
            stage_q <= '0;
        else if (!stall_i)
            stage_q <= d_i;
    end

    assign q_o = stage_q;

endmodule

//--- verilog/riscv_pkg.sv
//------------------------------
// types shared by the pipeline control core
// stage packets, trap kinds and control bundles
//------------------------------
`include "pipe_settings.svh"

package riscv_pkg;

    // trap kind that travels with an instruction down to MEM
    typedef enum logic [1:0] {
        NO_TRAP = 2'd0,
        MRET    = 2'd1,
        ILLEGAL = 2'd2
    } exc_t;

    // source of a redirected fetch PC
    typedef enum logic {
        PC_JUMP = 1'b0,
        PC_MEPC = 1'b1
    } pc_sel_t;

    // decoded instruction as seen in ID, all zero means bubble
    typedef struct packed {
        logic                    valid;
        logic [`PIPE_REG_AW-1:0] rs1_addr;
        logic [`PIPE_REG_AW-1:0] rs2_addr;
        logic [`PIPE_REG_AW-1:0] rd_addr;
        logic                    write_rd;
        // set for loads, writeback takes dmem data
        logic                    wb_use_mem;
        logic                    is_csr;
        exc_t                    is_mret;
        logic [`PIPE_XLEN-1:0]   pc;
    } id_pkt_t;

    // EX/MEM payload, instruction plus ALU result
    typedef struct packed {
        id_pkt_t               id;
        logic [`PIPE_XLEN-1:0] alu_result;
    } ex_pkt_t;

    // MEM/WB payload, adds the load data
    typedef struct packed {
        ex_pkt_t               ex;
        logic [`PIPE_XLEN-1:0] dmem_rdata;
    } mem_pkt_t;

    // operand forwarding selects and data for the EX stage
    typedef struct packed {
        logic                  forward_ex_mem_rs1;
        logic                  forward_ex_mem_rs2;
        logic                  forward_mem_wb_rs1;
        logic                  forward_mem_wb_rs2;
        logic [`PIPE_XLEN-1:0] forward_ex_mem_data;
        logic [`PIPE_XLEN-1:0] forward_mem_wb_data;
    } fwd_t;

    // flush, stall and PC steering levels from the controller
    typedef struct packed {
        logic    if_id_flush;
        logic    if_id_stall;
        logic    id_ex_flush;
        logic    id_ex_stall;
        logic    ex_mem_flush;
        logic    ex_mem_stall;
        logic    new_pc_en;
        pc_sel_t pc_sel;
        logic    csr_mret;
    } pipe_ctl_t;

endpackage

//--- verilog/trap_csr.sv
//------------------------------
// machine trap CSRs, mepc plus a count of taken MRETs
//------------------------------
`timescale 1ns/100ps
`include "pipe_settings.svh"

module trap_csr
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  csr_we_i,
    input  logic [`PIPE_XLEN-1:0] csr_wdata_i,
    // MRET acknowledged by the controller
    input  logic                  mret_i,
    output logic [`PIPE_XLEN-1:0] mepc_o,
    output logic [7:0]            mret_count_o
);

    logic [`PIPE_XLEN-1:0] mepc_q;
    logic [7:0]            mret_count_q;

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            mepc_q       <= '0;
            mret_count_q <= '0;
        end
        else
        begin
            // mepc visible the cycle after the write strobe
            if (csr_we_i)
                mepc_q <= csr_wdata_i;
            // wraps after 255 returns
            if (mret_i)
                mret_count_q <= mret_count_q + 8'd1;
        end
    end

    assign mepc_o       = mepc_q;
    assign mret_count_o = mret_count_q;

endmodule
